/* project.f */
+incdir+dv
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_control.sv
hw/rv_core.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the RV32I core testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
	-f project.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^PASS: all tests$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* dv/tb_tests.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I testbench programs
// Instruction encoders, reference models for ALU, branch,
// load and store results, and the test program builders
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op_reg};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opc_store};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::opc_branch};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] up, logic [4:0] rd, logic [6:0] opc);
	return {up, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::opc_jal};
endfunction

// Expected ALU value with shift encodings behaving as OR
function automatic logic [31:0] ref_result(logic [2:0] f3, logic b30, logic [31:0] a,
		logic [31:0] b);
	case (f3)
		3'b000: return b30 ? a - b : a + b;
		3'b010: return {31'b0, $signed(a) < $signed(b)};
		3'b011: return {31'b0, a < b};
		3'b100: return a ^ b;
		3'b111: return a & b;
		default: return a | b;
	endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
	case (f3)
		3'b000: return a == b;
		3'b001: return a != b;
		3'b100: return $signed(a) < $signed(b);
		3'b101: return $signed(a) >= $signed(b);
		3'b110: return a < b;
		default: return a >= b;
	endcase
endfunction

// Addressed lane shifted down to bit 0 and then sign or zero extended
function automatic logic [31:0] load_ref(logic [2:0] f3, logic [1:0] off, logic [31:0] w);
	logic [31:0] sh;
	sh = w >> (8 * off);
	case (f3[1:0])
		2'b00: return f3[2] ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
		2'b01: return f3[2] ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
		default: return w;
	endcase
endfunction

// Memory fill hashed from the byte address
function automatic logic [31:0] fill_word(int idx);
	logic [31:0] addr;
	addr = 32'(idx) << 2;
	return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0000;
endfunction

function automatic logic [31:0] merge_word(logic [31:0] old, logic [31:0] d, logic [3:0] s);
	logic [31:0] w;
	w = old;
	for (int i = 0; i < 4; i++) begin
		if (s[i]) begin
			w[8*i +: 8] = d[8*i +: 8];
		end
	end
	return w;
endfunction

function automatic void start_program(int base);
	prog.delete();
	exp_addr.delete();
	exp_data.delete();
	exp_strb.delete();
	next_addr = base;
endfunction

function automatic void emit(logic [31:0] w);
	prog.push_back(w);
endfunction

// Always two instructions with LUI then ADDI
function automatic void load_const(logic [4:0] rd, logic [31:0] v);
	logic [31:0] up;
	up = (v + 32'h800) >> 12;
	emit(enc_u(up[19:0], rd, rv_pkg::opc_lui));
	emit(enc_i(v[11:0], rd, 3'b000, rd, rv_pkg::opc_op_imm));
endfunction

function automatic void store_op(logic [2:0] f3, logic [4:0] rs, logic [11:0] addr,
		logic [31:0] d, logic [3:0] s);
	emit(enc_s(addr, rs, 5'd0, f3));
	// Base register is x0 so the address is the sign-extended offset
	exp_addr.push_back({{20{addr[11]}}, addr});
	exp_data.push_back(d);
	exp_strb.push_back(s);
endfunction

function automatic void store_word(logic [4:0] rs, logic [31:0] d);
	store_op(3'b010, rs, 12'(next_addr), d, 4'hf);
	next_addr += 4;
endfunction

function automatic void build_arith();
	logic [31:0] a;
	logic [31:0] b;
	logic [11:0] imm;
	start_program(32'h100);
	for (int f3 = 0; f3 < 9; f3++) begin
		a = $urandom;
		b = $urandom;
		load_const(5'd1, a);
		load_const(5'd2, b);
		// Pass 8 is SUB
		emit(enc_r(f3 == 8 ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
		store_word(5'd3, ref_result(3'(f3), f3 == 8, a, b));
	end
	for (int f3 = 0; f3 < 8; f3++) begin
		a = $urandom;
		imm = 12'($urandom);
		load_const(5'd1, a);
		emit(enc_i(imm, 5'd1, 3'(f3), 5'd4, rv_pkg::opc_op_imm));
		store_word(5'd4, ref_result(3'(f3), 1'b0, a, {{20{imm[11]}}, imm}));
	end
endfunction

function automatic void build_branch();
	logic [2:0] codes [6];
	logic [31:0] a;
	logic [31:0] b;
	codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
	start_program(32'h180);
	for (int n = 0; n < 12; n++) begin
		a = $urandom;
		// Second round uses equal operands
		b = (n < 6) ? $urandom : a;
		load_const(5'd1, a);
		load_const(5'd2, b);
		emit(enc_b(13'd12, 5'd2, 5'd1, codes[n % 6]));
		emit(enc_i(12'd0, 5'd0, 3'b000, 5'd5, rv_pkg::opc_op_imm));
		emit(enc_j(21'd8, 5'd0));
		emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, rv_pkg::opc_op_imm));
		store_word(5'd5, {31'b0, branch_taken(codes[n % 6], a, b)});
	end
endfunction

function automatic void build_loads();
	logic [31:0] w;
	start_program(32'h300);
	w = $urandom;
	load_const(5'd1, w);
	store_op(3'b010, 5'd1, 12'h200, w, 4'hf);
	for (int f3 = 0; f3 < 6; f3++) begin
		for (int off = 0; off < 4; off++) begin
			// Bytes at every offset, halves at 0 and 2, word at 0
			if ((f3 % 4 == 0) || (f3 % 4 == 1 && off % 2 == 0) || (f3 == 2 && off == 0)) begin
				emit(enc_i(12'h200 + 12'(off), 5'd0, 3'(f3), 5'd3, rv_pkg::opc_load));
				store_word(5'd3, load_ref(3'(f3), 2'(off), w));
			end
		end
	end
endfunction

function automatic void build_stores();
	logic [31:0] v;
	start_program(32'h400);
	v = $urandom;
	load_const(5'd1, v);
	for (int off = 0; off < 4; off++) begin
		store_op(3'b000, 5'd1, 12'h400 + 12'(5 * off), {4{v[7:0]}}, 4'b0001 << off);
	end
	store_op(3'b001, 5'd1, 12'h410, {2{v[15:0]}}, 4'b0011);
	store_op(3'b001, 5'd1, 12'h416, {2{v[15:0]}}, 4'b1100);
	// Odd half offsets land as if bit 0 were clear
	store_op(3'b001, 5'd1, 12'h419, {2{v[15:0]}}, 4'b0011);
	store_op(3'b001, 5'd1, 12'h41f, {2{v[15:0]}}, 4'b1100);
endfunction

function automatic void build_jumps();
	start_program(32'h500);
	emit(enc_j(21'd8, 5'd6));
	emit(enc_j(21'd0, 5'd0));
	store_word(5'd6, rv_pkg::reset_pc + 32'd4);
	load_const(5'd7, rv_pkg::reset_pc + 32'd28);
	emit(enc_i(12'd0, 5'd7, 3'b000, 5'd8, rv_pkg::opc_jalr));
	emit(enc_j(21'd0, 5'd0));
	store_word(5'd8, rv_pkg::reset_pc + 32'd24);
	emit(enc_u(20'h1, 5'd9, rv_pkg::opc_auipc));
	store_word(5'd9, rv_pkg::reset_pc + 32'd32 + 32'h1000);
endfunction

`endif

/* dv/tb_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core testbench
// Clock, reset, instruction and data memory models with
// random wait states, store checker and test sequence
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_top;

	logic          clock;
	logic          reset;
	rv_pkg::word_t iaddr;
	rv_pkg::word_t idata;
	logic          ivalid;
	logic          iready;
	rv_pkg::word_t daddr;
	rv_pkg::word_t dwdata;
	rv_pkg::word_t drdata;
	logic [3:0]    dstrb;
	logic          dwrite;
	logic          dvalid;
	logic          dready;

	rv_pkg::word_t imem [0:255];
	rv_pkg::word_t dmem [0:1023];
	logic          backpressure;
	logic          timed_out;
	int            iwait;
	int            dwait;
	rv_pkg::word_t prog [$];
	rv_pkg::word_t exp_addr [$];
	rv_pkg::word_t exp_data [$];
	logic [3:0]    exp_strb [$];
	rv_pkg::word_t st_addr [$];
	rv_pkg::word_t st_data [$];
	logic [3:0]    st_strb [$];
	int            checked;
	int            next_addr;
	int            test_checks;
	int            test_errors;
	int            total_checks;
	int            total_errors;
	int            tests_run;

	rv_core u_dut (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dstrb  (dstrb),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	`include "tb_tests.svh"

	always #20 clock = ~clock;

	task automatic check(input rv_pkg::word_t got, input rv_pkg::word_t expected,
			input string msg);
		test_checks++;
		if (got !== expected) begin
			test_errors++;
			$display("ERR %0t: %s, got %h expected %h", $time, msg, got, expected);
		end
	endtask

	// Instruction memory with 0 to 3 wait cycles under back-pressure
	always @(posedge clock) begin
		#2;
		if (!ivalid) begin
			iready = 1'b0;
			iwait = -1;
		end else begin
			if (iwait < 0) begin
				iwait = backpressure ? int'($urandom % 4) : 0;
			end
			if (iwait == 0) begin
				iready = 1'b1;
				idata = imem[iaddr[9:2]];
			end else begin
				iready = 1'b0;
				iwait--;
			end
		end
	end

	// Data memory applies the access in the cycle dready goes up
	always @(posedge clock) begin
		#2;
		if (!dvalid) begin
			dready = 1'b0;
			dwait = -1;
		end else begin
			if (dwait < 0) begin
				dwait = backpressure ? int'($urandom % 4) : 0;
			end
			if (dwait == 0) begin
				dready = 1'b1;
				drdata = dmem[daddr[11:2]];
				if (dwrite) begin
					dmem[daddr[11:2]] = merge_word(dmem[daddr[11:2]], dwdata, dstrb);
					st_addr.push_back(daddr);
					st_data.push_back(dwdata);
					st_strb.push_back(dstrb);
				end
			end else begin
				dready = 1'b0;
				dwait--;
			end
		end
	end

	// Store checker against the expected queues
	always @(negedge clock) begin
		while (checked < st_data.size()) begin
			if (checked < exp_data.size()) begin
				check(st_addr[checked], exp_addr[checked], "store address");
				check(st_data[checked], exp_data[checked], "store data");
				check(32'(st_strb[checked]), 32'(exp_strb[checked]), "store strobes");
			end else begin
				check(32'(st_data.size()), 32'(exp_data.size()), "store count");
			end
			checked++;
		end
	end

	// Bus requests stay off during reset
	always @(negedge clock) begin
		if (reset) begin
			check(32'(ivalid), 32'd0, "ivalid in reset");
			check(32'(dvalid), 32'd0, "dvalid in reset");
		end
	end

	task automatic run_program(input logic bp, input string name);
		int t;
		if (timed_out) begin
			return;
		end
		@(posedge clock);
		#2;
		reset = 1'b1;
		backpressure = bp;
		st_addr.delete();
		st_data.delete();
		st_strb.delete();
		checked = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : enc_j(21'd0, 5'd0);
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fill_word(i);
		end
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		t = 0;
		@(negedge clock);
		while (!ivalid && t < 50) begin
			@(negedge clock);
			t++;
		end
		if (!ivalid) begin
			$display("timeout: no instruction fetch after reset in test %s", name);
			timed_out = 1'b1;
		end else begin
			check(iaddr, rv_pkg::reset_pc, "first fetch address");
			t = 0;
			while (checked < exp_data.size() && t < 5000) begin
				@(negedge clock);
				t++;
			end
			if (checked < exp_data.size()) begin
				$display("timeout: test %s saw %0d of %0d stores", name, checked,
					exp_data.size());
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		void'($urandom(39));
		clock = 1'b0;
		reset = 1'b1;
		idata = '0;
		iready = 1'b0;
		drdata = '0;
		dready = 1'b0;
		backpressure = 1'b0;
		timed_out = 1'b0;
		iwait = -1;
		dwait = -1;
		checked = 0;
		test_checks = 0;
		test_errors = 0;
		total_checks = 0;
		total_errors = 0;
		tests_run = 0;

		build_arith();
		run_program(1'b0, "arith");
		finish_test("arith");
		// Same program and results with random wait states
		run_program(1'b1, "arith_backpressure");
		finish_test("arith_backpressure");
		build_branch();
		run_program(1'b0, "branch");
		finish_test("branch");
		build_loads();
		run_program(1'b0, "loads");
		finish_test("loads");
		build_stores();
		run_program(1'b0, "stores");
		for (int k = 0; k < 8; k++) begin
			check(dmem[256 + k], merge_word(fill_word(256 + k), exp_data[k], exp_strb[k]),
				"memory word after store");
		end
		finish_test("stores");
		build_jumps();
		run_program(1'b0, "jumps");
		finish_test("jumps");

		$display("tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
		if (total_errors == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I multi-cycle core, top level
// Connects control, decode, register file, ALU and LSU to
// the valid/ready instruction and data buses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module rv_core (
	input  logic          clock,
	input  logic          reset,
	output rv_pkg::word_t iaddr,
	input  rv_pkg::word_t idata,
	output logic          ivalid,
	input  logic          iready,
	output rv_pkg::word_t daddr,
	output rv_pkg::word_t dwdata,
	input  rv_pkg::word_t drdata,
	output logic [3:0]    dstrb,
	output logic          dwrite,
	output logic          dvalid,
	input  logic          dready
);

	// Fetched instruction and decoded fields
	rv_pkg::word_t    instr;
	logic             is_lui, is_auipc, is_jal, is_jalr, is_branch;
	logic             is_load, is_store, is_arith, is_slt;
	rv_pkg::reg_idx_t rs1, rs2, rd;
	rv_pkg::word_t    imm;
	logic [2:0]       funct3;
	rv_pkg::alu_op_t  dec_alu_op;
	rv_pkg::cmp_op_t  dec_cmp_op;

	// Register file ports
	rv_pkg::reg_idx_t ra_addr, rb_addr, rd_addr;
	rv_pkg::word_t    ra_data, rb_data, rd_data;
	logic             rd_wen;

	// ALU
	rv_pkg::word_t    op_a, op_b, result;
	rv_pkg::alu_op_t  alu_op;
	rv_pkg::cmp_op_t  cmp_op;
	logic             cond;

	// LSU handshake with control
	logic             mem_start, mem_done;
	rv_pkg::word_t    load_data;

	rv_control u_control (.*);

	rv_decode u_decode (
		.alu_op (dec_alu_op),
		.cmp_op (dec_cmp_op),
		.*
	);

	rv_regfile u_regfile (.*);

	rv_alu u_alu (.*);

	// Address straight from the ALU sum, store data from rs2
	rv_lsu u_lsu (
		.addr       (result),
		.store_data (rb_data),
		.*
	);

endmodule

`default_nettype wire

/* hw/rv_control.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I control unit
// Fetch/decode/execute/mem FSM, PC and instruction register,
// ALU operand muxing and register writeback selection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module rv_control (
	input  logic             clock,
	input  logic             reset,
	output rv_pkg::word_t    iaddr,
	input  rv_pkg::word_t    idata,
	output logic             ivalid,
	input  logic             iready,
	output rv_pkg::word_t    instr,
	input  logic             is_lui, is_auipc, is_jal, is_jalr, is_branch,
	input  logic             is_load, is_store, is_arith, is_slt,
	input  rv_pkg::reg_idx_t rs1, rs2, rd,
	input  rv_pkg::word_t    imm,
	input  rv_pkg::alu_op_t  dec_alu_op,
	input  rv_pkg::cmp_op_t  dec_cmp_op,
	output rv_pkg::reg_idx_t ra_addr, rb_addr,
	input  rv_pkg::word_t    ra_data, rb_data,
	output rv_pkg::reg_idx_t rd_addr,
	output rv_pkg::word_t    rd_data,
	output logic             rd_wen,
	output rv_pkg::word_t    op_a, op_b,
	output rv_pkg::alu_op_t  alu_op,
	output rv_pkg::cmp_op_t  cmp_op,
	input  rv_pkg::word_t    result,
	input  logic             cond,
	output logic             mem_start,
	input  logic             mem_done,
	input  rv_pkg::word_t    load_data
);

	rv_pkg::state_t state;
	rv_pkg::word_t  pc;
	rv_pkg::word_t  pc_plus4;
	rv_pkg::word_t  pc_next;
	logic           take_branch;
	logic           reg_form;
	logic           writes_rd;

	assign pc_plus4 = pc + 32'd4;
	assign iaddr = pc;
	assign ivalid = !reset && state == rv_pkg::st_fetch;

	// Register form takes rs2 instead of the immediate
	assign reg_form = instr[6:0] == rv_pkg::opc_op_reg;
	assign writes_rd = is_lui || is_auipc || is_jal || is_jalr || is_arith;

	// Register indices sit at fixed fields
	assign ra_addr = rs1;
	assign rb_addr = rs2;
	assign rd_addr = rd;
	assign alu_op = dec_alu_op;
	assign cmp_op = dec_cmp_op;

	// Jump and taken branch targets come from the ALU sum
	assign pc_next = (is_jal || is_jalr || (is_branch && take_branch)) ?
		{result[31:1], 1'b0} : pc_plus4;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rv_pkg::st_fetch;
			pc <= rv_pkg::reset_pc;
		end else begin
			case (state)
				rv_pkg::st_fetch: begin
					if (ivalid && iready) begin
						state <= rv_pkg::st_decode;
					end
				end
				rv_pkg::st_decode: begin
					state <= rv_pkg::st_execute;
				end
				rv_pkg::st_execute: begin
					if (is_load || is_store) begin
						state <= rv_pkg::st_mem;
					end else begin
						pc <= pc_next;
						state <= rv_pkg::st_fetch;
					end
				end
				default: begin
					// Wait out the data handshake
					if (mem_done) begin
						pc <= pc_plus4;
						state <= rv_pkg::st_fetch;
					end
				end
			endcase
		end
	end

	// Instruction capture and branch outcome
	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
		// Compare of rs1 against rs2 happens in decode
		if (state == rv_pkg::st_decode) begin
			take_branch <= cond;
		end
	end

	// Operand muxing
	always_comb begin
		op_a = ra_data;
		op_b = rb_data;
		// Decode keeps both register operands for the branch compare
		if (state != rv_pkg::st_decode) begin
			if (is_lui) begin
				op_a = imm;
				op_b = '0;
			end else if (is_auipc || is_jal || is_branch) begin
				op_a = pc;
				op_b = imm;
			end else if (!reg_form) begin
				op_b = imm;
			end
		end
	end

	// Writeback data
	always_comb begin
		if (is_jal || is_jalr) begin
			rd_data = pc_plus4;
		end else if (is_slt) begin
			rd_data = {31'b0, cond};
		end else if (is_load) begin
			rd_data = load_data;
		end else begin
			rd_data = result;
		end
	end

	// FENCE and unknown opcodes write nothing
	assign rd_wen = !reset && ((state == rv_pkg::st_execute && writes_rd) ||
		(state == rv_pkg::st_mem && is_load && mem_done));

	assign mem_start = state == rv_pkg::st_execute && (is_load || is_store);

	// Data handshake only completes while the FSM waits in mem
	assert property (@(posedge clock) disable iff (reset)
		mem_done |-> state == rv_pkg::st_mem);

endmodule

`default_nettype wire

/* hw/rv_lsu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I load/store unit
// Holds one data bus request until dready, places store
// lanes and strobes, extracts and extends load lanes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
	input  logic          clock,
	input  logic          reset,
	input  logic          mem_start,
	input  logic          is_store,
	input  logic [2:0]    funct3,
	input  rv_pkg::word_t addr,
	input  rv_pkg::word_t store_data,
	output logic          mem_done,
	output rv_pkg::word_t load_data,
	output rv_pkg::word_t daddr,
	output rv_pkg::word_t dwdata,
	output logic [3:0]    dstrb,
	output logic          dwrite,
	output logic          dvalid,
	input  rv_pkg::word_t drdata,
	input  logic          dready
);

	logic          pending;
	logic [2:0]    funct3_q;
	rv_pkg::word_t wdata;
	logic [3:0]    strb;
	logic [7:0]    lane_b;
	logic [15:0]   lane_h;

	// Store lanes, data replicated so any strobe picks it up
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				wdata = {4{store_data[7:0]}};
				strb = 4'b0001 << addr[1:0];
			end
			2'b01: begin
				// Bit 0 ignored
				wdata = {2{store_data[15:0]}};
				strb = addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata = store_data;
				strb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (mem_start) begin
			pending <= 1'b1;
		end else if (mem_done) begin
			pending <= 1'b0;
		end
	end

	// Request payload, held until the handshake
	always_ff @(posedge clock) begin
		if (mem_start) begin
			daddr <= addr;
			dwdata <= wdata;
			dstrb <= strb;
			dwrite <= is_store;
			funct3_q <= funct3;
		end
	end

	assign dvalid = pending && !reset;
	assign mem_done = dvalid && dready;

	// Load lane select, zero extend when funct3[2] set
	always_comb begin
		lane_b = drdata[8*daddr[1:0] +: 8];
		lane_h = daddr[1] ? drdata[31:16] : drdata[15:0];
		case (funct3_q[1:0])
			2'b00: load_data = {{24{lane_b[7] && !funct3_q[2]}}, lane_b};
			2'b01: load_data = {{16{lane_h[15] && !funct3_q[2]}}, lane_h};
			default: load_data = drdata;
		endcase
	end

	// Address held under back-pressure
	assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> $stable(daddr));

endmodule

`default_nettype wire

/* hw/rv_alu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I ALU and compare unit
// Add, sub and logic ops, plus eq/lt/ltu compare with the
// branch sense inversion
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
	input  rv_pkg::word_t   op_a,
	input  rv_pkg::word_t   op_b,
	input  rv_pkg::alu_op_t alu_op,
	input  rv_pkg::cmp_op_t cmp_op,
	input  logic [2:0]      funct3,
	output rv_pkg::word_t   result,
	output logic            cond
);

	logic match;
	logic invert;

	always_comb begin
		case (alu_op)
			rv_pkg::alu_add: result = op_a + op_b;
			rv_pkg::alu_sub: result = op_a - op_b;
			rv_pkg::alu_xor: result = op_a ^ op_b;
			rv_pkg::alu_or: result = op_a | op_b;
			default: result = op_a & op_b;
		endcase
	end

	always_comb begin
		case (cmp_op)
			rv_pkg::cmp_eq: match = op_a == op_b;
			rv_pkg::cmp_lt: match = $signed(op_a) < $signed(op_b);
			default: match = op_a < op_b;
		endcase
	end

	// BNE, BGE, BGEU flip the sense
	// SLTU (011) shares bit 0 but must not flip
	assign invert = funct3[0] && (funct3[2] || !funct3[1]);
	assign cond = match ^ invert;

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I register file
// 32 x 32 bits, two asynchronous reads, one clocked write,
// x0 hardwired to zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
	input  logic             clock,
	input  logic             reset,
	input  rv_pkg::reg_idx_t ra_addr,
	input  rv_pkg::reg_idx_t rb_addr,
	output rv_pkg::word_t    ra_data,
	output rv_pkg::word_t    rb_data,
	input  rv_pkg::reg_idx_t rd_addr,
	input  rv_pkg::word_t    rd_data,
	input  logic             rd_wen
);

	rv_pkg::word_t regs [0:31];

	// x0 reads as zero, entry 0 is never written
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

	always_ff @(posedge clock) begin
		if (rd_wen && rd_addr != '0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// Control must hold writes off throughout reset
	assert property (@(posedge clock) reset |-> !rd_wen);

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction decoder
// Opcode classification, register fields, immediate
// selection and ALU/comparator function mapping
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
	input  rv_pkg::word_t    instr,
	output logic             is_lui, is_auipc, is_jal, is_jalr, is_branch,
	output logic             is_load, is_store, is_arith, is_slt,
	output rv_pkg::reg_idx_t rs1, rs2, rd,
	output rv_pkg::word_t    imm,
	output logic [2:0]       funct3,
	output rv_pkg::alu_op_t  alu_op,
	output rv_pkg::cmp_op_t  cmp_op
);

	logic [6:0]    opcode;
	rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = instr[6:0];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];

	// Immediate formats, all sign extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		is_lui = 1'b0;
		is_auipc = 1'b0;
		is_jal = 1'b0;
		is_jalr = 1'b0;
		is_branch = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_arith = 1'b0;
		case (opcode)
			rv_pkg::opc_lui: is_lui = 1'b1;
			rv_pkg::opc_auipc: is_auipc = 1'b1;
			rv_pkg::opc_jal: is_jal = 1'b1;
			rv_pkg::opc_jalr: is_jalr = 1'b1;
			rv_pkg::opc_branch: is_branch = 1'b1;
			rv_pkg::opc_load: is_load = 1'b1;
			rv_pkg::opc_store: is_store = 1'b1;
			rv_pkg::opc_op_imm, rv_pkg::opc_op_reg: is_arith = 1'b1;
			// Nothing to order with one access in flight
			rv_pkg::opc_fence: ;
			default: ;
		endcase
	end

	// SLT, SLTI, SLTU, SLTIU
	assign is_slt = is_arith && funct3[2:1] == 2'b01;

	// Immediate by class, I-type otherwise
	always_comb begin
		if (is_lui || is_auipc) begin
			imm = imm_u;
		end else if (is_jal) begin
			imm = imm_j;
		end else if (is_branch) begin
			imm = imm_b;
		end else if (is_store) begin
			imm = imm_s;
		end else begin
			imm = imm_i;
		end
	end

	// ALU function, address and target sums default to add
	always_comb begin
		alu_op = rv_pkg::alu_add;
		if (is_arith) begin
			case (funct3)
				// SUB only in register form
				3'b000: alu_op = (instr[5] && instr[30]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
				3'b100: alu_op = rv_pkg::alu_xor;
				3'b111: alu_op = rv_pkg::alu_and;
				// SLT result comes from the comparator
				3'b010, 3'b011: alu_op = rv_pkg::alu_sub;
				// OR plus both shift encodings
				default: alu_op = rv_pkg::alu_or;
			endcase
		end
	end

	// Comparator function
	always_comb begin
		if (is_arith) begin
			cmp_op = funct3[0] ? rv_pkg::cmp_ltu : rv_pkg::cmp_lt;
		end else begin
			case (funct3[2:1])
				2'b10: cmp_op = rv_pkg::cmp_lt;
				2'b11: cmp_op = rv_pkg::cmp_ltu;
				default: cmp_op = rv_pkg::cmp_eq;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core shared definitions
// Data widths, major opcodes and the reset vector, plus the
// enums used by the decoder, ALU and control FSM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_pkg;

	// Datapath width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// First fetch address out of reset
	localparam word_t reset_pc = 32'h8000_0000;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op_reg = 7'b0110011;
	localparam logic [6:0] opc_fence  = 7'b0001111;

	// ALU functions, shifts fold into OR
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_xor,
		alu_or,
		alu_and
	} alu_op_t;

	// Comparator functions
	typedef enum logic [1:0] {
		cmp_eq,
		cmp_lt,
		cmp_ltu
	} cmp_op_t;

	// Control FSM
	typedef enum logic [1:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_mem
	} state_t;

endpackage

`default_nettype wire
